// File: source/kd_node_pkg.sv
package kd_node_pkg;

	// point geometry
	localparam int coord_width = 8;
	localparam int dims = 3;
	localparam int center_width = dims * coord_width;

	// one link word holds two packed points side by side
	localparam int data_width = 2 * center_width;
	localparam int lo_lsb = 0;
	localparam int hi_lsb = center_width;

	localparam int axis_width = 2;
	localparam int command_width = 6;

	// link command codes, a nonzero code is a one-cycle token
	typedef enum logic [command_width-1:0] {
		nop                      = 6'h00,
		configure_sort_axis      = 6'h02,
		receive_center           = 6'h03,
		configure_sort_axis_done = 6'h07,
		ready_to_sort            = 6'h0a,
		dne                      = 6'h10,
		rst_done                 = 6'h1e,
		rst                      = 6'h1f,
		accomulate               = 6'h22,
		return_sums              = 6'h23
	} command_t;

	// what data_to_top carries with a reply
	typedef enum logic [1:0] {
		kind_zero,
		kind_center,
		kind_sums
	} reply_kind_t;

	// counter must hold max_points itself
	function automatic int count_width_of(int max_points);
		return $clog2(max_points + 1);
	endfunction

	// room for max_points full-scale coordinates
	function automatic int sum_width_of(int max_points);
		return coord_width + count_width_of(max_points);
	endfunction

	function automatic logic [coord_width-1:0] coord_of(logic [center_width-1:0] point, int idx);
		return point[idx * coord_width +: coord_width];
	endfunction

endpackage

// File: source/node_decode.sv
`timescale 1ns/1ps

module node_decode (
	input  logic                               clk,
	input  logic                               rst_n,
	input  kd_node_pkg::command_t              command_from_top,
	input  logic [kd_node_pkg::data_width-1:0] data_from_top,
	input  kd_node_pkg::command_t              command_from_left,
	input  logic [kd_node_pkg::data_width-1:0] data_from_left,
	input  kd_node_pkg::command_t              command_from_right,
	input  logic [kd_node_pkg::data_width-1:0] data_from_right,
	input  kd_node_pkg::command_t              pending_kind,
	output kd_node_pkg::command_t              top_op,
	output logic [kd_node_pkg::data_width-1:0] top_data,
	output logic                               left_complete,
	output logic                               right_complete,
	output logic                               left_dne,
	output logic                               right_dne
);
	import kd_node_pkg::*;

	command_t top_cmd_q;
	command_t left_cmd_q;
	command_t right_cmd_q;
	logic [data_width-1:0] top_data_q;
	logic waiting;

	// control side of the links
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			top_cmd_q <= nop;
			left_cmd_q <= nop;
			right_cmd_q <= nop;
		end else begin
			top_cmd_q <= command_from_top;
			left_cmd_q <= command_from_left;
			right_cmd_q <= command_from_right;
		end
	end

	// top payload
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			top_data_q <= '0;
		end else begin
			top_data_q <= data_from_top;
		end
	end

	// child data carries nothing for the kept command set
	// done tokens are recognised by their code alone

	assign top_op = top_cmd_q;
	assign top_data = top_data_q;

	// an absent child drives dne every cycle
	assign left_dne = (left_cmd_q == dne);
	assign right_dne = (right_cmd_q == dne);

	// nop pending kind means nothing is awaited
	assign waiting = (pending_kind != nop);

	// done token of the awaited kind, or child missing altogether
	assign left_complete = left_dne || (waiting && left_cmd_q == pending_kind);
	assign right_complete = right_dne || (waiting && right_cmd_q == pending_kind);

endmodule

// File: source/node_execute.sv
`timescale 1ns/1ps

module node_execute #(
	parameter int  max_points = 31,
	localparam int count_width = kd_node_pkg::count_width_of(max_points),
	localparam int sum_width = kd_node_pkg::sum_width_of(max_points)
) (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  kd_node_pkg::command_t                top_op,
	input  logic [kd_node_pkg::data_width-1:0]   top_data,
	input  logic                                 left_complete,
	input  logic                                 right_complete,
	output kd_node_pkg::command_t                pending_kind,
	output kd_node_pkg::command_t                reply_cmd,
	output kd_node_pkg::reply_kind_t             reply_kind,
	output kd_node_pkg::command_t                forward_cmd,
	output logic [kd_node_pkg::data_width-1:0]   forward_data,
	output logic [kd_node_pkg::center_width-1:0] center,
	output logic [sum_width-1:0]                 sum_x,
	output logic [sum_width-1:0]                 sum_y,
	output logic [sum_width-1:0]                 sum_z,
	output logic [count_width-1:0]               point_count
);
	import kd_node_pkg::*;

	logic [center_width-1:0] center_q, center_d;
	logic [axis_width-1:0] axis_q, axis_d;
	logic [sum_width-1:0] sum_q [dims];
	logic [sum_width-1:0] sum_d [dims];
	logic [count_width-1:0] count_q, count_d;
	command_t pending_q, pending_d;
	command_t done_kind;
	logic left_seen_q, left_seen_d;
	logic right_seen_q, right_seen_d;
	logic starting, waiting, done;
	logic [center_width-1:0] best_center;

	assign best_center = top_data[hi_lsb +: center_width];

	// rst and configure both wait on the children
	assign starting = (top_op == rst) || (top_op == configure_sort_axis);
	assign waiting = (pending_q != nop);
	assign done_kind = !starting ? pending_q :
		(top_op == rst) ? rst_done : configure_sort_axis_done;

	// each child either done already, done now, or absent
	assign done = (starting || waiting) &&
		(left_seen_q || left_complete) && (right_seen_q || right_complete);

	always_comb begin
		center_d = center_q;
		axis_d = axis_q;
		sum_d = sum_q;
		count_d = count_q;
		pending_d = pending_q;
		// sticky only while something is awaited
		left_seen_d = waiting && (left_seen_q || left_complete);
		right_seen_d = waiting && (right_seen_q || right_complete);
		reply_cmd = nop;
		reply_kind = kind_zero;
		forward_cmd = nop;
		forward_data = top_data;

		case (top_op)
			receive_center: begin
				center_d = top_data[lo_lsb +: center_width];
				reply_cmd = ready_to_sort;
				reply_kind = kind_center;
			end
			accomulate: begin
				if (best_center == center_q) begin
					// point belongs to this node's cluster
					for (int i = 0; i < dims; i++) begin
						sum_d[i] = sum_q[i] +
							sum_width'(coord_of(top_data[lo_lsb +: center_width], i));
					end
					count_d = count_q + count_width'(1);
				end else begin
					// some node below owns it
					forward_cmd = accomulate;
				end
			end
			return_sums: begin
				reply_cmd = return_sums;
				reply_kind = kind_sums;
			end
			configure_sort_axis: begin
				axis_d = top_data[axis_width-1:0];
				forward_cmd = configure_sort_axis;
			end
			rst: begin
				forward_cmd = rst;
			end
			default: begin
			end
		endcase

		// open a wait unless both children are already settled
		if (starting && !done) begin
			pending_d = done_kind;
			left_seen_d = left_complete;
			right_seen_d = right_complete;
		end

		if (done) begin
			reply_cmd = done_kind;
			reply_kind = kind_zero;
			pending_d = nop;
			left_seen_d = 1'b0;
			right_seen_d = 1'b0;
			// rst wipes the node only once the subtree is clear
			if (done_kind == rst_done) begin
				center_d = '0;
				axis_d = '0;
				count_d = '0;
				for (int i = 0; i < dims; i++) begin
					sum_d[i] = '0;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			center_q <= '0;
			axis_q <= '0;
			count_q <= '0;
			pending_q <= nop;
			left_seen_q <= 1'b0;
			right_seen_q <= 1'b0;
			for (int i = 0; i < dims; i++) begin
				sum_q[i] <= '0;
			end
		end else begin
			center_q <= center_d;
			axis_q <= axis_d;
			count_q <= count_d;
			pending_q <= pending_d;
			left_seen_q <= left_seen_d;
			right_seen_q <= right_seen_d;
			sum_q <= sum_d;
		end
	end

	assign pending_kind = pending_q;

	// result samples the state as it stands after this edge
	assign center = center_d;
	assign sum_x = sum_d[0];
	assign sum_y = sum_d[1];
	assign sum_z = sum_d[2];
	assign point_count = count_d;

endmodule

// File: source/node_result.sv
`timescale 1ns/1ps

module node_result #(
	parameter int  max_points = 31,
	localparam int count_width = kd_node_pkg::count_width_of(max_points),
	localparam int sum_width = kd_node_pkg::sum_width_of(max_points)
) (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  kd_node_pkg::command_t                reply_cmd,
	input  kd_node_pkg::reply_kind_t             reply_kind,
	input  kd_node_pkg::command_t                forward_cmd,
	input  logic [kd_node_pkg::data_width-1:0]   forward_data,
	input  logic                                 left_dne,
	input  logic                                 right_dne,
	input  logic [kd_node_pkg::center_width-1:0] center,
	input  logic [sum_width-1:0]                 sum_x,
	input  logic [sum_width-1:0]                 sum_y,
	input  logic [sum_width-1:0]                 sum_z,
	input  logic [count_width-1:0]               point_count,
	output kd_node_pkg::command_t                command_to_top,
	output logic [kd_node_pkg::data_width-1:0]   data_to_top,
	output kd_node_pkg::command_t                command_to_left,
	output logic [kd_node_pkg::data_width-1:0]   data_to_left,
	output kd_node_pkg::command_t                command_to_right,
	output logic [kd_node_pkg::data_width-1:0]   data_to_right
);
	import kd_node_pkg::*;

	logic [data_width-1:0] top_word;
	logic left_go, right_go;

	// reply payload layout
	always_comb begin
		top_word = '0;
		case (reply_kind)
			kind_center: top_word[lo_lsb +: center_width] = center;
			kind_sums: begin
				// x, y, z from bit 0, counter on top of them
				top_word[0 +: sum_width] = sum_x;
				top_word[sum_width +: sum_width] = sum_y;
				top_word[2 * sum_width +: sum_width] = sum_z;
				top_word[3 * sum_width +: count_width] = point_count;
			end
			default: top_word = '0;
		endcase
	end

	// nothing goes down a missing branch
	assign left_go = (forward_cmd != nop) && !left_dne;
	assign right_go = (forward_cmd != nop) && !right_dne;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			command_to_top <= nop;
			data_to_top <= '0;
			command_to_left <= nop;
			data_to_left <= '0;
			command_to_right <= nop;
			data_to_right <= '0;
		end else begin
			command_to_top <= reply_cmd;
			data_to_top <= top_word;
			// idle child links show nop with zero data
			command_to_left <= left_go ? forward_cmd : nop;
			data_to_left <= left_go ? forward_data : '0;
			command_to_right <= right_go ? forward_cmd : nop;
			data_to_right <= right_go ? forward_data : '0;
		end
	end

endmodule

// File: source/kd_node.sv
`timescale 1ns/1ps

module kd_node #(
	parameter int max_points = 31
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  kd_node_pkg::command_t              command_from_top,
	input  logic [kd_node_pkg::data_width-1:0] data_from_top,
	input  kd_node_pkg::command_t              command_from_left,
	input  logic [kd_node_pkg::data_width-1:0] data_from_left,
	input  kd_node_pkg::command_t              command_from_right,
	input  logic [kd_node_pkg::data_width-1:0] data_from_right,
	output kd_node_pkg::command_t              command_to_top,
	output logic [kd_node_pkg::data_width-1:0] data_to_top,
	output kd_node_pkg::command_t              command_to_left,
	output logic [kd_node_pkg::data_width-1:0] data_to_left,
	output kd_node_pkg::command_t              command_to_right,
	output logic [kd_node_pkg::data_width-1:0] data_to_right
);
	import kd_node_pkg::*;

	localparam int count_width = count_width_of(max_points);
	localparam int sum_width = sum_width_of(max_points);

	// decode to execute
	command_t top_op;
	logic [data_width-1:0] top_data;
	logic left_complete, right_complete;
	command_t pending_kind;

	// decode to result
	logic left_dne, right_dne;

	// execute to result
	command_t reply_cmd, forward_cmd;
	reply_kind_t reply_kind;
	logic [data_width-1:0] forward_data;
	logic [center_width-1:0] center;
	logic [sum_width-1:0] sum_x, sum_y, sum_z;
	logic [count_width-1:0] point_count;

	// stage 1, link registers
	node_decode decode_i (
		.clk(clk), .rst_n(rst_n),
		.command_from_top(command_from_top), .data_from_top(data_from_top),
		.command_from_left(command_from_left), .data_from_left(data_from_left),
		.command_from_right(command_from_right), .data_from_right(data_from_right),
		.pending_kind(pending_kind), .top_op(top_op), .top_data(top_data),
		.left_complete(left_complete), .right_complete(right_complete),
		.left_dne(left_dne), .right_dne(right_dne)
	);

	// node state and per-command decisions
	node_execute #(.max_points(max_points)) execute_i (
		.clk(clk), .rst_n(rst_n), .top_op(top_op), .top_data(top_data),
		.left_complete(left_complete), .right_complete(right_complete),
		.pending_kind(pending_kind), .reply_cmd(reply_cmd), .reply_kind(reply_kind),
		.forward_cmd(forward_cmd), .forward_data(forward_data), .center(center),
		.sum_x(sum_x), .sum_y(sum_y), .sum_z(sum_z), .point_count(point_count)
	);

	// stage 2, output registers
	node_result #(.max_points(max_points)) result_i (
		.clk(clk), .rst_n(rst_n), .reply_cmd(reply_cmd), .reply_kind(reply_kind),
		.forward_cmd(forward_cmd), .forward_data(forward_data),
		.left_dne(left_dne), .right_dne(right_dne), .center(center),
		.sum_x(sum_x), .sum_y(sum_y), .sum_z(sum_z), .point_count(point_count),
		.command_to_top(command_to_top), .data_to_top(data_to_top),
		.command_to_left(command_to_left), .data_to_left(data_to_left),
		.command_to_right(command_to_right), .data_to_right(data_to_right)
	);

endmodule

// File: dv/kd_node_asserts.sv
`timescale 1ns/1ps

module kd_node_asserts #(
	parameter int max_points = 31
) (
	input logic                               clk,
	input logic                               rst_n,
	input kd_node_pkg::command_t              command_from_top,
	input logic [kd_node_pkg::data_width-1:0] data_from_top,
	input kd_node_pkg::command_t              command_from_left,
	input kd_node_pkg::command_t              command_from_right,
	input kd_node_pkg::command_t              command_to_top,
	input logic [kd_node_pkg::data_width-1:0] data_to_top,
	input kd_node_pkg::command_t              command_to_left,
	input logic [kd_node_pkg::data_width-1:0] data_to_left,
	input kd_node_pkg::command_t              command_to_right,
	input logic [kd_node_pkg::data_width-1:0] data_to_right
);
	import kd_node_pkg::*;

	// counter holds max_points, each sum adds that many full-scale coordinates
	localparam int count_w = $clog2(max_points + 1);
	localparam int sum_w = coord_width + count_w;

	command_t top_d1, top_d2;
	command_t left_d1, left_d2;
	command_t right_d1, right_d2;
	logic [data_width-1:0] data_d1, data_d2;
	logic match_d2;
	logic [center_width-1:0] center_m;
	logic [sum_w-1:0] sum_m [dims];
	logic [count_w-1:0] count_m;
	logic owe_left, owe_right;
	logic owes_after;
	logic [data_width-1:0] sums_word;
	int failures = 0;

	function automatic logic carries_done(command_t cmd);
		return cmd == rst_done || cmd == configure_sort_axis_done;
	endfunction

	function automatic logic opens_wait(command_t cmd);
		return cmd == rst || cmd == configure_sort_axis;
	endfunction

	function automatic command_t done_code(command_t cmd);
		return (cmd == rst) ? rst_done : configure_sort_axis_done;
	endfunction

	// rst, configure and foreign points travel down the tree
	function automatic logic goes_down(command_t cmd, logic match);
		return opens_wait(cmd) || (cmd == accomulate && !match);
	endfunction

	// link delay line plus the sums model
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			top_d1 <= nop;
			top_d2 <= nop;
			left_d1 <= nop;
			left_d2 <= nop;
			right_d1 <= nop;
			right_d2 <= nop;
			data_d1 <= '0;
			data_d2 <= '0;
			match_d2 <= 1'b0;
			center_m <= '0;
			count_m <= '0;
			owe_left <= 1'b0;
			owe_right <= 1'b0;
			owes_after <= 1'b0;
			for (int i = 0; i < dims; i++) begin
				sum_m[i] <= '0;
			end
		end else begin
			top_d1 <= command_from_top;
			top_d2 <= top_d1;
			left_d1 <= command_from_left;
			left_d2 <= left_d1;
			right_d1 <= command_from_right;
			right_d2 <= right_d1;
			data_d1 <= data_from_top;
			data_d2 <= data_d1;
			// best center against the center held before this edge
			match_d2 <= (data_d1[hi_lsb +: center_width] == center_m);
			if (command_to_top == rst_done) begin
				center_m <= '0;
				count_m <= '0;
				for (int i = 0; i < dims; i++) begin
					sum_m[i] <= '0;
				end
			end else if (top_d1 == receive_center) begin
				center_m <= data_d1[lo_lsb +: center_width];
			end else if (top_d1 == accomulate &&
				data_d1[hi_lsb +: center_width] == center_m) begin
				for (int i = 0; i < dims; i++) begin
					sum_m[i] <= sum_m[i] + sum_w'(data_d1[i * coord_width +: coord_width]);
				end
				count_m <= count_m + count_w'(1);
			end
			// a child owes a token from its forward until it answers
			if (opens_wait(command_to_left)) begin
				owe_left <= 1'b1;
			end else if (carries_done(command_from_left)) begin
				owe_left <= 1'b0;
			end
			if (opens_wait(command_to_right)) begin
				owe_right <= 1'b1;
			end else if (carries_done(command_from_right)) begin
				owe_right <= 1'b0;
			end
			// owe state as it stood after the token two edges back
			owes_after <= owe_left || owe_right;
		end
	end

	// x, y, z from bit 0 with the counter above
	assign sums_word = data_width'({count_m, sum_m[2], sum_m[1], sum_m[0]});

	assert property (@(posedge clk) disable iff (!rst_n)
		(top_d2 == nop && !carries_done(left_d2) && !carries_done(right_d2)) |->
		(command_to_top == nop && command_to_left == nop && command_to_right == nop))
		else begin
			failures += 1;
			$error("error command_to_top %h command_to_left %h command_to_right %h expected %h",
				command_to_top, command_to_left, command_to_right, nop);
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		top_d2 == receive_center |-> command_to_top == ready_to_sort &&
		data_to_top[center_width-1:0] == data_d2[center_width-1:0])
		else begin
			failures += 1;
			$error("error command_to_top %h data_to_top %h expected %h center %h",
				command_to_top, data_to_top, ready_to_sort, data_d2[center_width-1:0]);
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		goes_down(top_d2, match_d2) && left_d2 != dne |->
		command_to_left == top_d2 && data_to_left == data_d2)
		else begin
			failures += 1;
			$error("error command_to_left %h data_to_left %h expected %h %h",
				command_to_left, data_to_left, top_d2, data_d2);
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		goes_down(top_d2, match_d2) && right_d2 != dne |->
		command_to_right == top_d2 && data_to_right == data_d2)
		else begin
			failures += 1;
			$error("error command_to_right %h data_to_right %h expected %h %h",
				command_to_right, data_to_right, top_d2, data_d2);
		end

	// matched points and absent children see no traffic
	assert property (@(posedge clk) disable iff (!rst_n)
		(!goes_down(top_d2, match_d2) || left_d2 == dne) |-> command_to_left == nop)
		else begin
			failures += 1;
			$error("error command_to_left %h expected %h", command_to_left, nop);
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		(!goes_down(top_d2, match_d2) || right_d2 == dne) |-> command_to_right == nop)
		else begin
			failures += 1;
			$error("error command_to_right %h expected %h", command_to_right, nop);
		end

	// done reply only right after the last owed token
	assert property (@(posedge clk) disable iff (!rst_n)
		carries_done(command_to_top) |-> !owes_after &&
		(left_d2 == command_to_top || right_d2 == command_to_top ||
		(opens_wait(top_d2) && done_code(top_d2) == command_to_top &&
		left_d2 == dne && right_d2 == dne)))
		else begin
			failures += 1;
			$error("done reply came before every child had answered");
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		(carries_done(left_d2) || carries_done(right_d2)) && !owes_after |->
		command_to_top == (carries_done(left_d2) ? left_d2 : right_d2))
		else begin
			failures += 1;
			$error("error command_to_top %h expected %h", command_to_top,
				carries_done(left_d2) ? left_d2 : right_d2);
		end

	// both children gone, reply follows the command directly
	assert property (@(posedge clk) disable iff (!rst_n)
		opens_wait(top_d2) && left_d2 == dne && right_d2 == dne |->
		command_to_top == done_code(top_d2))
		else begin
			failures += 1;
			$error("error command_to_top %h expected %h", command_to_top, done_code(top_d2));
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		top_d2 == return_sums |-> command_to_top == return_sums && data_to_top == sums_word)
		else begin
			failures += 1;
			$error("error command_to_top %h data_to_top %h expected %h %h",
				command_to_top, data_to_top, return_sums, sums_word);
		end

endmodule

bind kd_node kd_node_asserts #(.max_points(max_points)) asserts_i (
	.clk, .rst_n, .command_from_top, .data_from_top, .command_from_left,
	.command_from_right, .command_to_top, .data_to_top, .command_to_left,
	.data_to_left, .command_to_right, .data_to_right
);

// File: dv/kd_node_tb.sv
`timescale 1ns/1ps

module kd_node_tb;
	import kd_node_pkg::*;

	localparam int max_points = 31;
	// whole run takes a few hundred cycles
	localparam int watchdog_cycles = 2000;
	localparam int reply_limit = 20;

	logic clk = 1'b0;
	logic rst_n;
	command_t command_from_top;
	logic [data_width-1:0] data_from_top;
	command_t command_from_left = nop;
	logic [data_width-1:0] data_from_left = '0;
	command_t command_from_right = nop;
	logic [data_width-1:0] data_from_right = '0;
	command_t command_to_top, command_to_left, command_to_right;
	logic [data_width-1:0] data_to_top, data_to_left, data_to_right;

	int seed = 32'hdaa1_1da1;
	logic left_absent, right_absent;
	int left_delay, right_delay;
	command_t left_token, right_token;
	int wait_errors;
	int tests_run;
	logic [center_width-1:0] center, best, point;

	kd_node #(.max_points(max_points)) dut_i (.*);

	always #5 clk = ~clk;

	function automatic command_t done_code(command_t cmd);
		return (cmd == rst) ? rst_done : configure_sort_axis_done;
	endfunction

	function automatic int failure_total();
		return wait_errors + dut_i.asserts_i.failures;
	endfunction

	// left child, answers rst or configure after 1 to 4 cycles
	always begin
		@(posedge clk);
		#1;
		command_from_left = left_absent ? dne : nop;
		if (!left_absent && (command_to_left == rst || command_to_left == configure_sort_axis)) begin
			left_token = done_code(command_to_left);
			left_delay = 1 + ({$random(seed)} % 4);
			repeat (left_delay) @(posedge clk);
			#1;
			command_from_left = left_token;
		end
	end

	// right child, same behavior
	always begin
		@(posedge clk);
		#1;
		command_from_right = right_absent ? dne : nop;
		if (!right_absent &&
			(command_to_right == rst || command_to_right == configure_sort_axis)) begin
			right_token = done_code(command_to_right);
			right_delay = 1 + ({$random(seed)} % 4);
			repeat (right_delay) @(posedge clk);
			#1;
			command_from_right = right_token;
		end
	end

	task automatic drive_top(command_t cmd, logic [data_width-1:0] data);
		@(posedge clk);
		#1;
		command_from_top = cmd;
		data_from_top = data;
	endtask

	task automatic idle(int cycles);
		repeat (cycles) drive_top(nop, '0);
	endtask

	// single token then back to nop
	task automatic send_top(command_t cmd, logic [data_width-1:0] data);
		drive_top(cmd, data);
		drive_top(nop, '0);
	endtask

	task automatic await_reply(command_t want);
		int n;
		n = 0;
		while (command_to_top != want && n < reply_limit) begin
			@(negedge clk);
			n++;
		end
		if (command_to_top != want) begin
			$display("reply %s never came back from the node", want.name());
			wait_errors++;
		end
	endtask

	// command that waits on the children
	task automatic settle(command_t cmd, logic [data_width-1:0] data);
		send_top(cmd, data);
		await_reply(done_code(cmd));
		idle(2);
	endtask

	task automatic report(string name);
		tests_run++;
		$display("test %0d %s finished, failures so far %0d", tests_run, name, failure_total());
	endtask

	initial begin
		rst_n = 1'b0;
		command_from_top = nop;
		data_from_top = '0;
		left_absent = 1'b0;
		right_absent = 1'b0;
		wait_errors = 0;
		tests_run = 0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// quiet links after reset
		idle(8);
		report("idle after reset");

		center = 24'h40_80_c0;
		send_top(receive_center, {24'h0, center});
		await_reply(ready_to_sort);
		report("center load");

		// both children, then each one missing, then none
		settle(configure_sort_axis, 48'h2);
		settle(rst, '0);
		left_absent = 1'b1;
		idle(3);
		settle(configure_sort_axis, 48'h1);
		settle(rst, '0);
		left_absent = 1'b0;
		right_absent = 1'b1;
		idle(3);
		settle(configure_sort_axis, 48'h3);
		settle(rst, '0);
		left_absent = 1'b1;
		idle(3);
		settle(configure_sort_axis, 48'h0);
		settle(rst, '0);
		left_absent = 1'b0;
		right_absent = 1'b0;
		idle(3);
		report("rst and configure");

		// center was wiped by rst
		send_top(receive_center, {24'h0, center});
		await_reply(ready_to_sort);
		send_top(accomulate, {center ^ 24'h01_00_00, 24'h11_22_33});
		send_top(accomulate, {center, 24'h05_06_07});
		right_absent = 1'b1;
		idle(3);
		send_top(accomulate, {center ^ 24'h00_00_80, 24'h7f_01_fe});
		idle(3);
		right_absent = 1'b0;
		idle(3);
		report("accumulate routing");

		settle(rst, '0);
		center = 24'h5a_a5_3c;
		send_top(receive_center, {24'h0, center});
		await_reply(ready_to_sort);
		for (int i = 0; i < 24; i++) begin
			point = 24'($random(seed));
			// low bit flip keeps a foreign best center distinct
			best = center ^ 24'($random(seed) | 1);
			if ({$random(seed)} % 2 == 0)
				best = center;
			drive_top(accomulate, {best, point});
			if ({$random(seed)} % 3 == 0)
				drive_top(nop, '0);
		end
		// readback right behind the last point
		send_top(return_sums, '0);
		await_reply(return_sums);
		idle(2);
		settle(rst, '0);
		send_top(return_sums, '0);
		await_reply(return_sums);
		idle(4);
		report("sums and readback");

		$display("tests run %0d, assertion failures %0d, missing replies %0d",
			tests_run, dut_i.asserts_i.failures, wait_errors);
		if (failure_total() == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog ran out after %0d cycles", watchdog_cycles);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: vlog.f
source/kd_node_pkg.sv
source/node_decode.sv
source/node_execute.sv
source/node_result.sv
source/kd_node.sv
dv/kd_node_asserts.sv
dv/kd_node_tb.sv

// File: Makefile
# Verilator build and run of the kd-tree node testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, fail if the log holds the fail message"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f vlog.f --top-module kd_node_tb \
		--Mdir obj_dir -o kd_node_sim
	./obj_dir/kd_node_sim +verilator+error+limit+1000 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG) || ! grep -q "=== PASS ===" $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
